//--- src/null_pkg.sv
package null_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int CNT_W   = 32;
  localparam int APB_AW  = 12;
  localparam int APB_DW  = 32;
  localparam int SID_W   = 32;
  localparam int LINES_W = 16;
  localparam int GAP_W   = 16;

  //////////////////////////////////////////////////////////////////////
  // CHDR header word
  //////////////////////////////////////////////////////////////////////

  // Field layout, MSB first
  typedef struct packed {
    logic [1:0]       pkt_type;
    logic             has_time;
    logic             eob;
    logic [11:0]      seqnum;
    logic [15:0]      length;
    logic [SID_W-1:0] sid;
  } chdr_fields_t;

  // Same word as bus data or as fields
  typedef union packed {
    logic [63:0]  raw;
    chdr_fields_t f;
  } chdr_hdr_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [APB_AW-1:0] REG_NOC_ID_LO = 12'h000;
  localparam logic [APB_AW-1:0] REG_NOC_ID_HI = 12'h004;

  // Settings register numbers, relative to SR_BASE
  localparam int SR_SID   = 0;
  localparam int SR_LINES = 1;
  localparam int SR_CTRL  = 2;

  // Bits of SR_CTRL
  localparam int CTRL_ENABLE  = 0;
  localparam int CTRL_CLEAR   = 1;
  localparam int CTRL_GAP_LSB = 16;

  localparam logic [APB_AW-1:0] RB_SRC_PKTS   = 12'h040;
  localparam logic [APB_AW-1:0] RB_SNK_PKTS   = 12'h044;
  localparam logic [APB_AW-1:0] RB_SNK_WORDS  = 12'h048;
  localparam logic [APB_AW-1:0] RB_SNK_LENERR = 12'h04C;

endpackage

//--- src/null_regs.sv
module null_regs
  import null_pkg::*;
#(
  parameter logic [63:0] NOC_ID  = 64'h0000_0000_0000_0000,
  parameter int          SR_BASE = 8
) (
  input  logic               i_clk,
  input  logic               i_arst_n,
  // APB slave
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  logic [APB_AW-1:0]  i_paddr,
  input  logic [APB_DW-1:0]  i_pwdata,
  output logic [APB_DW-1:0]  o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  // Counters from source and sink
  input  logic [CNT_W-1:0]   i_src_pkts,
  input  logic [CNT_W-1:0]   i_snk_pkts,
  input  logic [CNT_W-1:0]   i_snk_words,
  input  logic [CNT_W-1:0]   i_snk_lenerr,
  // Source settings
  output logic [SID_W-1:0]   o_sid,
  output logic [LINES_W-1:0] o_lines,
  output logic               o_enable,
  output logic [GAP_W-1:0]   o_gap,
  output logic               o_clear
);

  localparam logic [APB_AW-1:0] ADDR_SID   = APB_AW'(4 * (SR_BASE + SR_SID));
  localparam logic [APB_AW-1:0] ADDR_LINES = APB_AW'(4 * (SR_BASE + SR_LINES));
  localparam logic [APB_AW-1:0] ADDR_CTRL  = APB_AW'(4 * (SR_BASE + SR_CTRL));

  logic               wr_en;
  logic [LINES_W-1:0] wr_lines;

  // No wait states, no errors
  assign o_pready  = 1'b1;
  assign o_pslverr = 1'b0;

  // Write lands on the edge closing the access phase
  assign wr_en = i_psel & i_penable & i_pwrite;

  // Zero lines would give an empty packet, keep at least one
  assign wr_lines = (i_pwdata[LINES_W-1:0] == '0) ? LINES_W'(1) : i_pwdata[LINES_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Settings
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sid    <= '0;
      o_lines  <= LINES_W'(1);
      o_enable <= 1'b0;
      o_gap    <= '0;
      o_clear  <= 1'b0;
    end else begin
      // Clear is a single-cycle pulse
      o_clear <= 1'b0;
      if (wr_en) begin
        case (i_paddr)
          ADDR_SID: begin
            o_sid <= i_pwdata[SID_W-1:0];
          end
          ADDR_LINES: begin
            o_lines <= wr_lines;
          end
          ADDR_CTRL: begin
            o_enable <= i_pwdata[CTRL_ENABLE];
            o_clear  <= i_pwdata[CTRL_CLEAR];
            o_gap    <= i_pwdata[CTRL_GAP_LSB +: GAP_W];
          end
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (i_paddr)
        REG_NOC_ID_LO: o_prdata = NOC_ID[31:0];
        REG_NOC_ID_HI: o_prdata = NOC_ID[63:32];
        ADDR_SID:      o_prdata = o_sid;
        ADDR_LINES:    o_prdata = {{(APB_DW-LINES_W){1'b0}}, o_lines};
        // Clear bit always reads back as zero
        ADDR_CTRL:     o_prdata = {o_gap, 14'd0, 1'b0, o_enable};
        RB_SRC_PKTS:   o_prdata = i_src_pkts;
        RB_SNK_PKTS:   o_prdata = i_snk_pkts;
        RB_SNK_WORDS:  o_prdata = i_snk_words;
        RB_SNK_LENERR: o_prdata = i_snk_lenerr;
        default:       o_prdata = '0;
      endcase
    end
  end

  // Access phase only inside a selected transfer
  a_penable_in_psel: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_penable |-> i_psel
  );

endmodule

//--- src/null_source.sv
module null_source
  import null_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic [SID_W-1:0]   i_sid,
  input  logic [LINES_W-1:0] i_lines,
  input  logic               i_enable,
  input  logic [GAP_W-1:0]   i_gap,
  input  logic               i_clear,
  output logic [63:0]        o_tdata,
  output logic               o_tlast,
  output logic               o_tvalid,
  input  logic               i_tready,
  output logic [CNT_W-1:0]   o_src_pkts
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_PAY,
    ST_GAP
  } state_t;

  state_t             state;
  state_t             state_nx;
  logic               beat_ok;
  logic               pkt_done;
  logic               load;
  logic [SID_W-1:0]   sid_lat;
  logic [LINES_W-1:0] lines_lat;
  logic [GAP_W-1:0]   gap_lat;
  logic [LINES_W-1:0] line_cnt;
  logic [GAP_W-1:0]   gap_cnt;
  logic [11:0]        seq;
  logic               seq_clr_pend;
  chdr_hdr_t          hdr;

  assign o_tvalid = (state == ST_HDR) || (state == ST_PAY);
  assign o_tlast  = (state == ST_PAY) && (line_cnt == lines_lat - 1'b1);
  assign beat_ok  = o_tvalid & i_tready;
  assign pkt_done = beat_ok & o_tlast;

  always_comb begin
    hdr            = '0;
    hdr.f.pkt_type = 2'd0;
    hdr.f.seqnum   = seq;
    hdr.f.length   = 16'({lines_lat, 3'b000} + 19'd8);
    hdr.f.sid      = sid_lat;
  end

  // Payload line k holds sequence number and k
  assign o_tdata = (state == ST_HDR) ? hdr.raw : {20'd0, seq, 16'd0, line_cnt};

  //////////////////////////////////////////////////////////////////////
  // Packet FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE: if (i_enable) state_nx = ST_HDR;
      ST_HDR:  if (beat_ok) state_nx = ST_PAY;
      ST_PAY: begin
        if (pkt_done) begin
          if (gap_lat != '0) state_nx = ST_GAP;
          else state_nx = i_enable ? ST_HDR : ST_IDLE;
        end
      end
      ST_GAP:  if (gap_cnt <= GAP_W'(1)) state_nx = i_enable ? ST_HDR : ST_IDLE;
      default: state_nx = ST_IDLE;
    endcase
  end

  // Settings are sampled once per packet
  assign load = (state_nx == ST_HDR) && (state != ST_HDR);

  always_ff @(posedge i_clk) begin
    if (load) begin
      sid_lat   <= i_sid;
      lines_lat <= i_lines;
      gap_lat   <= i_gap;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state        <= ST_IDLE;
      line_cnt     <= '0;
      gap_cnt      <= '0;
      seq          <= '0;
      seq_clr_pend <= 1'b0;
      o_src_pkts   <= '0;
    end else begin
      state <= state_nx;
      if (state == ST_HDR) line_cnt <= '0;
      else if (beat_ok && !o_tlast) line_cnt <= line_cnt + 1'b1;

      if (pkt_done) gap_cnt <= gap_lat;
      else if (state == ST_GAP) gap_cnt <= gap_cnt - 1'b1;

      // A clear mid-packet waits for the packet to end
      if (pkt_done) begin
        seq          <= (seq_clr_pend || i_clear) ? 12'd0 : seq + 12'd1;
        seq_clr_pend <= 1'b0;
      end else if (i_clear) begin
        if (o_tvalid) seq_clr_pend <= 1'b1;
        else seq <= 12'd0;
      end

      if (i_clear) o_src_pkts <= '0;
      else if (pkt_done) o_src_pkts <= o_src_pkts + 1'b1;
    end
  end

  a_hold_stalled: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast)
  );

endmodule

//--- src/null_sink.sv
module null_sink
  import null_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic [63:0]      i_tdata,
  input  logic             i_tlast,
  input  logic             i_tvalid,
  output logic             o_tready,
  input  logic             i_clear,
  output logic [CNT_W-1:0] o_snk_pkts,
  output logic [CNT_W-1:0] o_snk_words,
  output logic [CNT_W-1:0] o_snk_lenerr
);

  chdr_hdr_t   hdr_in;
  logic        beat_ok;
  logic        in_hdr;
  logic [15:0] exp_len;
  logic [15:0] beat_cnt;
  logic [15:0] cur_len;
  logic [15:0] cur_beats;
  logic        len_bad;

  assign hdr_in.raw = i_tdata;
  assign beat_ok    = i_tvalid & o_tready;

  // Header beat starts the count, later beats add to it
  assign cur_len   = in_hdr ? hdr_in.f.length : exp_len;
  assign cur_beats = in_hdr ? 16'd1 : beat_cnt + 16'd1;
  assign len_bad   = ({cur_beats, 3'b000} != {3'b000, cur_len});

  // Ready rises on the first cycle out of reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_tready <= 1'b0;
    end else begin
      o_tready <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Framing and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_hdr       <= 1'b1;
      exp_len      <= '0;
      beat_cnt     <= '0;
      o_snk_pkts   <= '0;
      o_snk_words  <= '0;
      o_snk_lenerr <= '0;
    end else begin
      if (beat_ok) begin
        in_hdr   <= i_tlast;
        exp_len  <= cur_len;
        beat_cnt <= cur_beats;
      end

      if (i_clear) begin
        o_snk_pkts   <= '0;
        o_snk_words  <= '0;
        o_snk_lenerr <= '0;
      end else if (beat_ok) begin
        o_snk_words <= o_snk_words + 1'b1;
        if (i_tlast) begin
          o_snk_pkts <= o_snk_pkts + 1'b1;
          if (len_bad) o_snk_lenerr <= o_snk_lenerr + 1'b1;
        end
      end
    end
  end

  a_always_ready: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    $past(i_arst_n) |-> o_tready
  );

endmodule

//--- src/noc_block_null_source_sink.sv
module noc_block_null_source_sink
  import null_pkg::*;
#(
  parameter logic [63:0] NOC_ID  = 64'h0000_0000_0000_0000,
  parameter int          SR_BASE = 8
) (
  input  logic              ce_clk,
  input  logic              i_arst_n,
  // APB slave
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [APB_DW-1:0] i_pwdata,
  output logic [APB_DW-1:0] o_prdata,
  output logic              o_pready,
  output logic              o_pslverr,
  // Incoming stream
  input  logic [63:0]       i_tdata,
  input  logic              i_tlast,
  input  logic              i_tvalid,
  output logic              o_tready,
  // Outgoing stream
  output logic [63:0]       o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready
);

  logic [SID_W-1:0]   sid;
  logic [LINES_W-1:0] lines;
  logic               enable;
  logic [GAP_W-1:0]   gap;
  logic               clear;
  logic [CNT_W-1:0]   src_pkts;
  logic [CNT_W-1:0]   snk_pkts;
  logic [CNT_W-1:0]   snk_words;
  logic [CNT_W-1:0]   snk_lenerr;

  null_regs #(
    .NOC_ID  (NOC_ID),
    .SR_BASE (SR_BASE)
  ) u_regs (
    .i_clk        (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .i_src_pkts   (src_pkts),
    .i_snk_pkts   (snk_pkts),
    .i_snk_words  (snk_words),
    .i_snk_lenerr (snk_lenerr),
    .o_sid        (sid),
    .o_lines      (lines),
    .o_enable     (enable),
    .o_gap        (gap),
    .o_clear      (clear)
  );

  // Test packet generator
  null_source u_source (
    .i_clk      (ce_clk),
    .i_arst_n   (i_arst_n),
    .i_sid      (sid),
    .i_lines    (lines),
    .i_enable   (enable),
    .i_gap      (gap),
    .i_clear    (clear),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_tready   (i_tready),
    .o_src_pkts (src_pkts)
  );

  // Drops everything, keeps statistics
  null_sink u_sink (
    .i_clk        (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .i_clear      (clear),
    .o_snk_pkts   (snk_pkts),
    .o_snk_words  (snk_words),
    .o_snk_lenerr (snk_lenerr)
  );

endmodule

//--- testbench/tb_null_checks.sv
module tb_null_checks (
  input  logic        i_clk,
  input  logic        i_arst_n,
  // APB response
  input  logic        i_psel,
  input  logic        i_pready,
  input  logic        i_pslverr,
  // Outgoing stream from the DUT
  input  logic [63:0] i_out_tdata,
  input  logic        i_out_tlast,
  input  logic        i_out_tvalid,
  input  logic        i_out_tready,
  // Incoming stream into the DUT
  input  logic        i_in_tlast,
  input  logic        i_in_tvalid,
  input  logic        i_in_tready,
  // Expected source settings and phase control
  input  logic [31:0] i_exp_sid,
  input  logic [15:0] i_exp_lines,
  input  logic        i_quiet,
  input  logic        i_restart,
  output logic [31:0] o_out_pkts,
  output logic [31:0] o_in_pkts,
  output logic [31:0] o_in_beats,
  output logic        o_fail
);

  logic        out_hs;
  logic        in_hs;
  logic [15:0] beat_idx;
  logic [11:0] exp_seq;
  logic        held;
  logic [63:0] held_data;
  logic        held_last;
  bit          fail_fmt;
  bit          fail_hold;
  bit          fail_valid;
  bit          fail_quiet;
  bit          fail_apb;
  bit          fail_ready;

  assign out_hs = i_out_tvalid & i_out_tready;
  assign in_hs  = i_in_tvalid & i_in_tready;
  assign o_fail = fail_fmt | fail_hold | fail_valid | fail_quiet | fail_apb | fail_ready;

  //////////////////////////////////////////////////////////////////////
  // Packet format and scoreboard
  //////////////////////////////////////////////////////////////////////

  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      beat_idx   <= '0;
      exp_seq    <= '0;
      held       <= 1'b0;
      held_data  <= '0;
      held_last  <= 1'b0;
      o_out_pkts <= '0;
      o_in_pkts  <= '0;
      o_in_beats <= '0;
    end else begin
      // A stalled beat comes back unchanged
      if (held && i_out_tvalid) begin
        assert (i_out_tdata == held_data && i_out_tlast == held_last) else begin
          $display("mismatch o_tdata/o_tlast under stall: held %h/%h now %h/%h",
                   held_data, held_last, i_out_tdata, i_out_tlast);
          fail_hold <= 1'b1;
        end
      end
      held      <= i_out_tvalid && !i_out_tready;
      held_data <= i_out_tdata;
      held_last <= i_out_tlast;

      if (i_restart) begin
        beat_idx   <= '0;
        exp_seq    <= '0;
        o_out_pkts <= '0;
        o_in_pkts  <= '0;
        o_in_beats <= '0;
      end else begin
        if (out_hs) begin
          if (beat_idx == 16'd0) begin
            // Header fields from the top are type, time, eob, seq, length and sid
            assert (i_out_tdata[31:0] == i_exp_sid) else begin
              $display("mismatch o_tdata sid: got %h expected %h",
                       i_out_tdata[31:0], i_exp_sid);
              fail_fmt <= 1'b1;
            end
            assert (i_out_tdata[47:32] == 16'((i_exp_lines + 16'd1) * 16'd8)) else begin
              $display("mismatch o_tdata length: got %h expected %h",
                       i_out_tdata[47:32], 16'((i_exp_lines + 16'd1) * 16'd8));
              fail_fmt <= 1'b1;
            end
            assert (i_out_tdata[59:48] == exp_seq) else begin
              $display("mismatch o_tdata seqnum: got %h expected %h",
                       i_out_tdata[59:48], exp_seq);
              fail_fmt <= 1'b1;
            end
            assert (i_out_tdata[63:62] == 2'd0) else begin
              $display("mismatch o_tdata pkt_type: got %h expected 0", i_out_tdata[63:62]);
              fail_fmt <= 1'b1;
            end
          end else begin
            assert (i_out_tdata == {32'(exp_seq), 32'(beat_idx - 16'd1)}) else begin
              $display("mismatch o_tdata payload: got %h expected %h",
                       i_out_tdata, {32'(exp_seq), 32'(beat_idx - 16'd1)});
              fail_fmt <= 1'b1;
            end
          end
          assert (i_out_tlast == (beat_idx == i_exp_lines)) else begin
            $display("mismatch o_tlast on beat %h: got %h", beat_idx, i_out_tlast);
            fail_fmt <= 1'b1;
          end
          if (i_out_tlast) begin
            beat_idx   <= '0;
            exp_seq    <= exp_seq + 12'd1;
            o_out_pkts <= o_out_pkts + 32'd1;
          end else begin
            beat_idx <= beat_idx + 16'd1;
          end
        end
        if (in_hs) begin
          o_in_beats <= o_in_beats + 32'd1;
          if (i_in_tlast) o_in_pkts <= o_in_pkts + 32'd1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol rules
  //////////////////////////////////////////////////////////////////////

  a_valid_held: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_out_tvalid && !i_out_tready |=> i_out_tvalid
  ) else begin
    $display("outgoing valid dropped while the beat was stalled");
    fail_valid = 1'b1;
  end

  // Nothing more once the final packet is out
  a_quiet: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_quiet |-> !i_out_tvalid
  ) else begin
    $display("outgoing valid rose after the final packet had finished");
    fail_quiet = 1'b1;
  end

  a_apb_resp: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_psel |-> i_pready && !i_pslverr
  ) else begin
    $display("mismatch o_pready/o_pslverr: got %h/%h expected 1/0", i_pready, i_pslverr);
    fail_apb = 1'b1;
  end

  a_sink_ready: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    $past(i_arst_n) |-> i_in_tready
  ) else begin
    $display("sink dropped ready outside reset");
    fail_ready = 1'b1;
  end

endmodule

//--- testbench/tb_null_block.sv
module tb_null_block;

  localparam logic [63:0] NOC_ID  = 64'h1234_5678_9ABC_DEF0;
  localparam int          SR_BASE = 8;

  // Register map, byte offsets
  localparam logic [11:0] ADDR_SID      = 12'(4 * (SR_BASE + 0));
  localparam logic [11:0] ADDR_LINES    = 12'(4 * (SR_BASE + 1));
  localparam logic [11:0] ADDR_CTRL     = 12'(4 * (SR_BASE + 2));
  localparam logic [11:0] RB_SRC_PKTS   = 12'h040;
  localparam logic [11:0] RB_SNK_PKTS   = 12'h044;
  localparam logic [11:0] RB_SNK_WORDS  = 12'h048;
  localparam logic [11:0] RB_SNK_LENERR = 12'h04C;

  logic        ce_clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [63:0] src_tdata;
  logic        src_tlast;
  logic        src_tvalid;
  logic        src_tready;
  logic [63:0] snk_tdata;
  logic        snk_tlast;
  logic        snk_tvalid;
  logic        snk_tready;
  // Injection path and stall source
  logic        sel_inject;
  logic [63:0] inj_tdata;
  logic        inj_tlast;
  logic        inj_tvalid;
  logic        stall_on;
  logic        stall_rdy = 1'b0;
  logic [31:0] lcg_state = 32'd90425;
  // Checker control and results
  logic [31:0] exp_sid;
  logic [15:0] exp_lines;
  logic        quiet;
  logic        restart;
  logic [31:0] chk_out_pkts;
  logic [31:0] chk_in_pkts;
  logic [31:0] chk_in_beats;
  logic        chk_fail;

  // Loopback with stalls, or a hand-built packet
  assign src_tready = stall_rdy & snk_tready & ~sel_inject;
  assign snk_tvalid = sel_inject ? inj_tvalid : (src_tvalid & stall_rdy);
  assign snk_tdata  = sel_inject ? inj_tdata : src_tdata;
  assign snk_tlast  = sel_inject ? inj_tlast : src_tlast;

  noc_block_null_source_sink #(
    .NOC_ID  (NOC_ID),
    .SR_BASE (SR_BASE)
  ) i_dut (
    .ce_clk    (ce_clk),
    .i_arst_n  (arst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .i_tdata   (snk_tdata),
    .i_tlast   (snk_tlast),
    .i_tvalid  (snk_tvalid),
    .o_tready  (snk_tready),
    .o_tdata   (src_tdata),
    .o_tlast   (src_tlast),
    .o_tvalid  (src_tvalid),
    .i_tready  (src_tready)
  );

  tb_null_checks u_checks (
    .i_clk        (ce_clk),
    .i_arst_n     (arst_n),
    .i_psel       (psel),
    .i_pready     (pready),
    .i_pslverr    (pslverr),
    .i_out_tdata  (src_tdata),
    .i_out_tlast  (src_tlast),
    .i_out_tvalid (src_tvalid),
    .i_out_tready (src_tready),
    .i_in_tlast   (snk_tlast),
    .i_in_tvalid  (snk_tvalid),
    .i_in_tready  (snk_tready),
    .i_exp_sid    (exp_sid),
    .i_exp_lines  (exp_lines),
    .i_quiet      (quiet),
    .i_restart    (restart),
    .o_out_pkts   (chk_out_pkts),
    .o_in_pkts    (chk_in_pkts),
    .o_in_beats   (chk_in_beats),
    .o_fail       (chk_fail)
  );

  initial begin
    ce_clk = 1'b0;
    forever #5 ce_clk = ~ce_clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Ready about five cycles in eight while stalling
  always @(posedge ce_clk) begin
    #1;
    if (stall_on) begin
      lcg_state = lcg_next(lcg_state);
      stall_rdy = (lcg_state[31:29] < 3'd5);
    end else begin
      stall_rdy = 1'b1;
    end
  end

  always @(posedge chk_fail) begin
    $display("Test FAILED");
    $fatal(1, "checker flagged an error");
  end

  //////////////////////////////////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge ce_clk);
    #1;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test FAILED");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    n = 0;
    while (!pready) begin
      tick();
      n++;
      if (n > 50) abort_on_timeout("PREADY on a write");
    end
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    n = 0;
    while (!pready) begin
      tick();
      n++;
      if (n > 50) abort_on_timeout("PREADY on a read");
    end
    data = prdata;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    apb_read(addr, got);
    assert (got == exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "register readback error");
    end
  endtask

  task automatic check_counters(input logic [31:0] exp_lenerr);
    read_check(RB_SRC_PKTS, chk_out_pkts, "rb_src_pkts");
    read_check(RB_SNK_PKTS, chk_in_pkts, "rb_snk_pkts");
    read_check(RB_SNK_WORDS, chk_in_beats, "rb_snk_words");
    read_check(RB_SNK_LENERR, exp_lenerr, "rb_snk_lenerr");
  endtask

  // Runs the source for a number of packets, then stops it
  task automatic run_burst(input logic [31:0] sid, input logic [15:0] lines,
                           input logic [15:0] gap, input int npkts, input logic stall);
    logic [31:0] target;
    int          n;
    exp_sid   = sid;
    exp_lines = lines;
    stall_on  = stall;
    quiet     = 1'b0;
    target    = chk_out_pkts + npkts;
    apb_write(ADDR_SID, sid);
    apb_write(ADDR_LINES, 32'(lines));
    apb_write(ADDR_CTRL, {gap, 15'd0, 1'b1});
    n = 0;
    while (chk_out_pkts < target) begin
      tick();
      n++;
      if (n > 20000) abort_on_timeout("packets from the source");
    end
    apb_write(ADDR_CTRL, {gap, 16'd0});
    n = 0;
    while (src_tvalid) begin
      tick();
      n++;
      if (n > 2000) abort_on_timeout("the end of the last packet");
    end
    quiet    = 1'b1;
    stall_on = 1'b0;
  endtask

  task automatic inject_packet(input int beats, input logic [15:0] decl_len);
    int   i;
    int   n;
    logic hs;
    sel_inject = 1'b1;
    for (i = 0; i < beats; i++) begin
      if (i == 0) inj_tdata = {4'h0, 12'hABC, decl_len, 32'hBAD0_0001};
      else inj_tdata = {32'hFEED_0000, 32'(i)};
      inj_tlast  = (i == beats - 1);
      inj_tvalid = 1'b1;
      hs = 1'b0;
      n = 0;
      while (!hs) begin
        hs = snk_tready;
        tick();
        n++;
        if (!hs && n > 100) abort_on_timeout("sink ready on an injected beat");
      end
    end
    inj_tvalid = 1'b0;
    inj_tlast  = 1'b0;
    sel_inject = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    arst_n     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    sel_inject = 1'b0;
    inj_tdata  = '0;
    inj_tlast  = 1'b0;
    inj_tvalid = 1'b0;
    stall_on   = 1'b0;
    quiet      = 1'b0;
    restart    = 1'b0;
    exp_sid    = '0;
    exp_lines  = 16'd1;
    repeat (4) @(posedge ce_clk);
    #1 arst_n = 1'b1;
    tick();

    // Register map
    read_check(12'h000, NOC_ID[31:0], "noc_id_lo");
    read_check(12'h004, NOC_ID[63:32], "noc_id_hi");
    apb_write(ADDR_SID, 32'hC0DE_0A51);
    apb_write(ADDR_LINES, 32'd7);
    apb_write(ADDR_CTRL, 32'h0005_0000);
    read_check(ADDR_SID, 32'hC0DE_0A51, "sr_sid");
    read_check(ADDR_LINES, 32'd7, "sr_lines");
    read_check(ADDR_CTRL, 32'h0005_0000, "sr_ctrl");
    read_check(12'h008, 32'd0, "unmapped 0x008");
    read_check(12'h02C, 32'd0, "unmapped 0x02c");
    read_check(12'h050, 32'd0, "unmapped 0x050");
    read_check(12'hFFC, 32'd0, "unmapped 0xffc");

    // Traffic with and without stalls
    run_burst(32'hC0FF_EE01, 16'd5, 16'd3, 25, 1'b1);
    check_counters(32'd0);
    run_burst(32'h0000_0B0B, 16'd1, 16'd0, 30, 1'b0);
    check_counters(32'd0);
    run_burst(32'h7700_0042, 16'd40, 16'd0, 4, 1'b1);
    check_counters(32'd0);

    // Declared 40 bytes, three beats sent
    inject_packet(3, 16'd40);
    check_counters(32'd1);
    inject_packet(3, 16'd24);
    check_counters(32'd1);

    // Clear, then sequence restarts at zero
    apb_write(ADDR_CTRL, 32'h0000_0002);
    restart = 1'b1;
    tick();
    restart = 1'b0;
    read_check(ADDR_CTRL, 32'd0, "sr_ctrl after clear");
    check_counters(32'd0);
    run_burst(32'h0000_5A5A, 16'd2, 16'd1, 6, 1'b1);
    check_counters(32'd0);

    if (chk_fail) begin
      $display("Test FAILED");
      $fatal(1, "checker flagged an error");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- project.f
src/null_pkg.sv
src/null_regs.sv
src/null_source.sv
src/null_sink.sv
src/noc_block_null_source_sink.sv
testbench/tb_null_checks.sv
testbench/tb_null_block.sv

//--- run.sh
#!/bin/sh
# Build and run the null source/sink simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_null_block \
  --Mdir obj_dir -o sim_null_block \
  -f project.f

./obj_dir/sim_null_block
